/* rtl/bcd_pkg.sv */
package bcd_pkg;

    // input value width, two's complement
    parameter int bin_width = 19;

    // enough digits for the magnitude of the most negative input
    parameter int bcd_digits = 6;

    typedef logic [bin_width-1:0] bin_t;

    typedef logic [3:0] digit_t;

    // least significant digit in the low nibble
    typedef logic [bcd_digits*$bits(digit_t)-1:0] bcd_t;

    typedef struct packed {
        bcd_t magnitude;
        logic negative;
    } bcd_result_t;

endpackage

/* rtl/display_pkg.sv */
package display_pkg;

    // six digit positions plus a leftmost sign position
    parameter int display_positions = 7;

    typedef enum logic [3:0] {
        glyph_0     = 4'd0,
        glyph_1     = 4'd1,
        glyph_2     = 4'd2,
        glyph_3     = 4'd3,
        glyph_4     = 4'd4,
        glyph_5     = 4'd5,
        glyph_6     = 4'd6,
        glyph_7     = 4'd7,
        glyph_8     = 4'd8,
        glyph_9     = 4'd9,
        glyph_blank = 4'd10,
        glyph_minus = 4'd11
    } glyph_e;

    // bit 6 is g, bit 0 is a
    typedef logic [6:0] segments_t;

    // one-hot, bit 0 is the rightmost position
    typedef logic [display_positions-1:0] position_sel_t;

    typedef struct packed {
        glyph_e pos6;
        glyph_e pos5;
        glyph_e pos4;
        glyph_e pos3;
        glyph_e pos2;
        glyph_e pos1;
        glyph_e pos0;
    } display_frame_t;

endpackage

/* rtl/bcd_converter.sv */
`timescale 1ns/10ps

module bcd_converter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    input  logic                  start,
    input  bcd_pkg::bin_t         value,
    output bcd_pkg::bcd_result_t  result,
    output logic                  ready
);

    localparam int count_w = $clog2(bcd_pkg::bin_width);
    localparam int digit_w = $bits(bcd_pkg::digit_t);
    localparam int bcd_w   = $bits(bcd_pkg::bcd_t);

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_add,
        st_done
    } state_e;

    state_e               state;
    state_e               state_next;
    logic [count_w-1:0]   shift_count;
    bcd_pkg::bin_t        magnitude;
    bcd_pkg::bcd_t        digits;
    logic                 negative;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else if (!enable) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            st_idle:  state_next = start ? st_shift : st_idle;
            // last shift goes straight to done, no add after it
            st_shift: state_next = (shift_count == count_w'(bcd_pkg::bin_width - 1)) ?
                                   st_done : st_add;
            st_add:   state_next = st_shift;
            st_done:  state_next = st_idle;
            default:  state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            shift_count <= '0;
        end else if (!enable || state == st_idle) begin
            shift_count <= '0;
        end else if (state == st_shift) begin
            shift_count <= shift_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (enable && state == st_idle) begin
            magnitude <= value[bcd_pkg::bin_width-1] ? (~value + 1'b1) : value;
        end else if (enable && state == st_shift) begin
            magnitude <= {magnitude[bcd_pkg::bin_width-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            digits   <= '0;
            negative <= 1'b0;
            ready    <= 1'b0;
        end else begin
            ready <= 1'b0;
            if (enable) begin
                case (state)
                    st_idle: begin
                        digits   <= '0;
                        negative <= value[bcd_pkg::bin_width-1];
                    end
                    st_shift: begin
                        digits <= {digits[bcd_w-2:0], magnitude[bcd_pkg::bin_width-1]};
                    end
                    st_add: begin
                        for (int i = 0; i < bcd_pkg::bcd_digits; i++) begin
                            if (digits[digit_w*i +: digit_w] > 4'd4) begin
                                digits[digit_w*i +: digit_w] <=
                                    digits[digit_w*i +: digit_w] + 4'd3;
                            end
                        end
                    end
                    st_done: begin
                        ready <= 1'b1;
                    end
                    default: begin
                        ready <= 1'b0;
                    end
                endcase
            end
        end
    end

    // digits are cleared on the idle cycle after the ready pulse
    assign result.magnitude = digits;
    assign result.negative  = negative;

endmodule

/* rtl/digit_formatter.sv */
`timescale 1ns/10ps

module digit_formatter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load,
    input  bcd_pkg::bcd_result_t         result,
    output display_pkg::display_frame_t  frame
);

    localparam int idx_w   = $clog2(display_pkg::display_positions);
    localparam int digit_w = $bits(bcd_pkg::digit_t);

    logic [idx_w-1:0]             lead;
    display_pkg::glyph_e          glyphs [display_pkg::display_positions];
    display_pkg::display_frame_t  frame_next;

    // lead is the most significant non-zero digit, digit 0 always shown
    always_comb begin
        lead = '0;
        for (int i = 1; i < bcd_pkg::bcd_digits; i++) begin
            if (result.magnitude[digit_w*i +: digit_w] != '0) begin
                lead = idx_w'(i);
            end
        end
    end

    always_comb begin
        for (int p = 0; p < display_pkg::display_positions; p++) begin
            glyphs[p] = display_pkg::glyph_blank;
        end
        for (int p = 0; p < bcd_pkg::bcd_digits; p++) begin
            if (idx_w'(p) <= lead) begin
                glyphs[p] = display_pkg::glyph_e'(result.magnitude[digit_w*p +: digit_w]);
            end
        end
        // sign sits just left of the leading digit
        if (result.negative) begin
            glyphs[lead + 1] = display_pkg::glyph_minus;
        end
    end

    always_comb begin
        frame_next.pos0 = glyphs[0];
        frame_next.pos1 = glyphs[1];
        frame_next.pos2 = glyphs[2];
        frame_next.pos3 = glyphs[3];
        frame_next.pos4 = glyphs[4];
        frame_next.pos5 = glyphs[5];
        frame_next.pos6 = glyphs[6];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame <= '{default: display_pkg::glyph_blank};
        end else if (load) begin
            frame <= frame_next;
        end
    end

endmodule

/* rtl/display_scanner.sv */
`timescale 1ns/10ps

module display_scanner #(
    parameter int scan_div = 50000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  display_pkg::display_frame_t  frame,
    output display_pkg::position_sel_t   position_sel,
    output display_pkg::segments_t       segments
);

    localparam int div_w   = (scan_div > 1) ? $clog2(scan_div) : 1;
    localparam int glyph_w = $bits(display_pkg::glyph_e);
    localparam int last    = display_pkg::display_positions - 1;

    logic [div_w-1:0]                                    prescale;
    logic                                                tick;
    display_pkg::position_sel_t                          sel_next;
    logic [glyph_w*display_pkg::display_positions-1:0]   frame_bits;
    display_pkg::glyph_e                                 glyph;

    function automatic display_pkg::segments_t seg_lookup(input display_pkg::glyph_e g);
        case (g)
            display_pkg::glyph_0:     return 7'h3f;
            display_pkg::glyph_1:     return 7'h06;
            display_pkg::glyph_2:     return 7'h5b;
            display_pkg::glyph_3:     return 7'h4f;
            display_pkg::glyph_4:     return 7'h66;
            display_pkg::glyph_5:     return 7'h6d;
            display_pkg::glyph_6:     return 7'h7d;
            display_pkg::glyph_7:     return 7'h07;
            display_pkg::glyph_8:     return 7'h7f;
            display_pkg::glyph_9:     return 7'h6f;
            display_pkg::glyph_minus: return 7'h40;
            default:                  return 7'h00;
        endcase
    endfunction

    assign tick       = (prescale == div_w'(scan_div - 1));
    assign frame_bits = frame;

    // rotate left, position 6 wraps to position 0
    assign sel_next = tick ? {position_sel[last-1:0], position_sel[last]} : position_sel;

    always_comb begin
        glyph = display_pkg::glyph_blank;
        for (int i = 0; i < display_pkg::display_positions; i++) begin
            if (sel_next[i]) begin
                glyph = display_pkg::glyph_e'(frame_bits[glyph_w*i +: glyph_w]);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prescale <= '0;
        end else if (tick) begin
            prescale <= '0;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // segments follow the same next position, so both outputs move together
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            position_sel <= display_pkg::position_sel_t'(1);
            segments     <= '0;
        end else begin
            position_sel <= sel_next;
            segments     <= seg_lookup(glyph);
        end
    end

endmodule

/* rtl/signed_display_top.sv */
`timescale 1ns/10ps

module signed_display_top #(
    parameter int scan_div = 50000
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        enable,
    input  logic                        start,
    input  bcd_pkg::bin_t               value,
    output bcd_pkg::bcd_result_t        result,
    output logic                        result_ready,
    output display_pkg::position_sel_t  position_sel,
    output display_pkg::segments_t      segments
);

    display_pkg::display_frame_t  frame;

    bcd_converter u_converter (
        .clk    (clk),
        .reset  (reset),
        .enable (enable),
        .start  (start),
        .value  (value),
        .result (result),
        .ready  (result_ready)
    );

    // holds the last finished conversion
    digit_formatter u_formatter (
        .clk    (clk),
        .reset  (reset),
        .load   (result_ready),
        .result (result),
        .frame  (frame)
    );

    display_scanner #(
        .scan_div (scan_div)
    ) u_scanner (
        .clk          (clk),
        .reset        (reset),
        .frame        (frame),
        .position_sel (position_sel),
        .segments     (segments)
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* testbench/tb_signed_display.sv */
`timescale 1ns/10ps

module tb_signed_display;

    localparam int scan_div    = 4;
    localparam int test_count  = 53;
    // conversion plus one full scan per test, margin of two
    localparam int watchdog_ns = test_count * (40 + 7 * scan_div) * 2 * 20;

    logic                  clk;
    logic                  reset;
    logic                  enable;
    logic                  start;
    bcd_pkg::bin_t         value;
    bcd_pkg::bcd_result_t  result;
    logic                  result_ready;
    logic [6:0]            position_sel;
    logic [6:0]            segments;
    logic [31:0]           rng_state = 32'h0b77_75fe;
    int                    checks = 0;
    int                    errors = 0;

    tb_clock_gen clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    signed_display_top #(
        .scan_div (scan_div)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .start        (start),
        .value        (value),
        .result       (result),
        .result_ready (result_ready),
        .position_sel (position_sel),
        .segments     (segments)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // decimal digits of the magnitude by repeated division
    function automatic bcd_pkg::bcd_t expected_bcd(input int v);
        int            mag;
        bcd_pkg::bcd_t bcd;
        mag = (v < 0) ? -v : v;
        for (int i = 0; i < 6; i++) begin
            bcd[4*i +: 4] = 4'(mag % 10);
            mag = mag / 10;
        end
        return bcd;
    endfunction

    // 10 is blank, 11 is minus
    function automatic int expected_glyph(input int v, input int pos);
        bcd_pkg::bcd_t bcd;
        int            lead;
        bcd = expected_bcd(v);
        lead = 0;
        for (int i = 1; i < 6; i++) begin
            if (bcd[4*i +: 4] != 4'd0) begin
                lead = i;
            end
        end
        if (pos <= lead) begin
            return int'(bcd[4*pos +: 4]);
        end
        if (v < 0 && pos == lead + 1) begin
            return 11;
        end
        return 10;
    endfunction

    function automatic int decode_segments(input logic [6:0] s);
        case (s)
            7'h3f:   return 0;
            7'h06:   return 1;
            7'h5b:   return 2;
            7'h4f:   return 3;
            7'h66:   return 4;
            7'h6d:   return 5;
            7'h7d:   return 6;
            7'h07:   return 7;
            7'h7f:   return 8;
            7'h6f:   return 9;
            7'h00:   return 10;
            7'h40:   return 11;
            default: return -1;
        endcase
    endfunction

    task automatic check_value(input string name, input int got, input int want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, want);
        end
    endtask

    task automatic check_true(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERROR at %0t: %s", $time, what);
        end
    endtask

    // one full scan, every position compared with the expected glyph
    task automatic read_display(input int v);
        logic [6:0] seen;
        int         pos;
        seen = '0;
        @(posedge clk);
        repeat (7 * scan_div) begin
            @(negedge clk);
            pos = -1;
            for (int i = 0; i < 7; i++) begin
                if (position_sel == 7'(1 << i)) begin
                    pos = i;
                end
            end
            check_true(pos >= 0, $sformatf("position_sel %b is not one-hot", position_sel));
            if (pos >= 0) begin
                seen[pos] = 1'b1;
                check_value($sformatf("segments glyph at position %0d", pos),
                            decode_segments(segments), expected_glyph(v, pos));
            end
        end
        check_true(seen == 7'h7f, $sformatf("scan visited only positions %b", seen));
    endtask

    task automatic convert_and_check(input int v, input int poke_at, input int poke_v);
        int   edges;
        logic seen_ready;
        edges = 0;
        seen_ready = 1'b0;
        @(posedge clk);
        value <= v[18:0];
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        // edges counted after the one that sampled start
        while (!seen_ready && edges < 40) begin
            @(posedge clk);
            edges++;
            if (edges == poke_at) begin
                start <= 1'b1;
                value <= poke_v[18:0];
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            seen_ready = result_ready;
        end
        check_true(seen_ready, $sformatf("no result_ready for value %0d", v));
        check_value("result_ready latency", edges, 38);
        check_value("result.magnitude", int'(result.magnitude), int'(expected_bcd(v)));
        check_value("result.negative", int'(result.negative), int'(v < 0));
        @(negedge clk);
        check_value("result_ready width", int'(result_ready), 0);
        read_display(v);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_value("result_ready", int'(result_ready), 0);
        check_value("segments", int'(segments), 0);
        check_value("position_sel", int'(position_sel), 1);
        check_value("result", int'(result), 0);
    endtask

    task automatic test_positive_values();
        int fixed_values[6] = '{0, 1, 9, 10, 99999, 262143};
        foreach (fixed_values[i]) begin
            convert_and_check(fixed_values[i], 0, 0);
        end
        repeat (20) begin
            rng_state = xorshift(rng_state);
            convert_and_check(int'(rng_state & 32'h3ffff), 0, 0);
        end
    endtask

    task automatic test_negative_values();
        int fixed_values[3] = '{-1, -10, -262144};
        foreach (fixed_values[i]) begin
            convert_and_check(fixed_values[i], 0, 0);
        end
        // sign bit forced, then sign extended from 19 bits
        repeat (20) begin
            rng_state = xorshift(rng_state);
            convert_and_check(int'((rng_state & 32'h7ffff) | 32'h40000) - 524288, 0, 0);
        end
    endtask

    task automatic test_abort_and_hold();
        int pulses;
        convert_and_check(-4321, 0, 0);
        @(posedge clk);
        value <= 19'd12345;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (10) @(posedge clk);
        enable <= 1'b0;
        pulses = 0;
        repeat (40) begin
            @(negedge clk);
            if (result_ready) begin
                pulses++;
            end
        end
        check_true(pulses == 0, "result_ready pulsed after the conversion was aborted");
        read_display(-4321);
        @(posedge clk);
        enable <= 1'b1;
        convert_and_check(54321, 10, -777);
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns with tests still running", watchdog_ns);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        enable = 1'b0;
        start = 1'b0;
        value = '0;
        @(negedge reset);
        test_reset_state();
        @(posedge clk);
        enable <= 1'b1;
        test_positive_values();
        test_negative_values();
        test_abort_and_hold();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
rtl/bcd_pkg.sv
rtl/display_pkg.sv
rtl/bcd_converter.sv
rtl/digit_formatter.sv
rtl/display_scanner.sv
rtl/signed_display_top.sv
testbench/tb_clock_gen.sv
testbench/tb_signed_display.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_signed_display \
    -Mdir obj_dir \
    -f filelist.f

./obj_dir/Vtb_signed_display | tee sim.log

if grep -q "^Simulation PASSED$" sim.log; then
    echo "run passed"
    exit 0
else
    echo "run failed"
    exit 1
fi
